// ==== common/cts_settings.svh ====
`ifndef CTS_SETTINGS_SVH
`define CTS_SETTINGS_SVH

// stream geometry
`define CTS_BITS_PER_SYMBOL 8
`define CTS_SYMBOLS_PER_BEAT 3
`define CTS_DATA_WIDTH (`CTS_BITS_PER_SYMBOL * `CTS_SYMBOLS_PER_BEAT)

// what counts as a format change
// with both cleared, every video frame triggers the writes
`define CTS_TRIGGER_ON_WIDTH 1
`define CTS_TRIGGER_ON_HEIGHT 1

// target register map
`define CTS_WIDTH_ADDR 8'h10
`define CTS_HEIGHT_ADDR 8'h11
`define CTS_INTERLACE_ADDR 8'h12

`endif

// ==== common/cts_pkg.sv ====
`include "cts_settings.svh"

package cts_pkg;

	// one stream beat with its packet markers
	typedef struct packed {
		logic [`CTS_DATA_WIDTH-1:0] data;
		logic sop;
		logic eop;
	} stream_beat_t;

	// frame format as carried by a control packet
	typedef struct packed {
		logic [15:0] width;
		logic [15:0] height;
		logic [3:0] interlaced;
	} frame_format_t;

	// one register write towards the target
	typedef struct packed {
		logic [7:0] address;
		logic [15:0] data;
	} reg_write_t;

	// low nibble of the first beat
	typedef enum logic [3:0] {
		PKT_VIDEO = 4'd0,
		PKT_CONTROL = 4'd15
	} packet_type_t;

	typedef enum logic [1:0] {
		WAIT_VIDEO_SOP,
		STOPPED,
		WRITING
	} sync_state_t;

	typedef enum logic [1:0] {
		W_IDLE,
		W_WIDTH,
		W_HEIGHT,
		W_INTERLACE
	} writer_state_t;

endpackage

// ==== source/cts_format_decoder.sv ====
`timescale 1ns/1ns
`include "cts_settings.svh"

module cts_format_decoder import cts_pkg::*; (
	input logic clk,
	input logic rst,
	input logic taken,
	input stream_beat_t taken_beat,
	output frame_format_t current_format
);

	// nibbles delivered by one beat, one per symbol
	localparam int NIBBLE_BITS = 4 * `CTS_SYMBOLS_PER_BEAT;
	localparam int FORMAT_BITS = $bits(frame_format_t);

	// index of the next beat in the packet, saturates past the format beats
	logic [2:0] beat_index;
	logic is_control;
	logic shift_beat;
	logic [NIBBLE_BITS-1:0] beat_nibbles;
	frame_format_t build_format;
	frame_format_t next_format;

	// symbol 0 lands in the most significant nibble
	always_comb begin
		for (int s = 0; s < `CTS_SYMBOLS_PER_BEAT; s++) begin
			beat_nibbles[NIBBLE_BITS-1-4*s -: 4] = taken_beat.data[s*`CTS_BITS_PER_SYMBOL +: 4];
		end
	end

	// beats 1 to 3 of a control packet hold the format
	assign shift_beat = taken && !taken_beat.sop && is_control &&
		(beat_index >= 3'd1) && (beat_index <= 3'd3);

	always_comb begin
		if (shift_beat) begin
			next_format = frame_format_t'({build_format[FORMAT_BITS-NIBBLE_BITS-1:0],
				beat_nibbles});
		end else begin
			next_format = build_format;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			beat_index <= 3'd0;
			is_control <= 1'b0;
			current_format <= '0;
		end else if (taken) begin
			if (taken_beat.sop) begin
				beat_index <= 3'd1;
				is_control <= (packet_type_t'(taken_beat.data[3:0]) == PKT_CONTROL);
			end else begin
				if (beat_index != 3'd4) begin
					beat_index <= beat_index + 3'd1;
				end
				// publish only once all nine nibbles are in
				if (taken_beat.eop && is_control && (beat_index >= 3'd3)) begin
					current_format <= next_format;
				end
			end
		end
	end

	// format under construction
	always_ff @(posedge clk) begin
		if (taken) begin
			build_format <= next_format;
		end
	end

endmodule

// ==== source/cts_register_writer.sv ====
`timescale 1ns/1ns
`include "cts_settings.svh"

module cts_register_writer import cts_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start_write,
	input frame_format_t write_format,
	output logic write_done,
	output reg_write_t wr_req,
	output logic wr_valid,
	input logic wr_ready
);

	writer_state_t state;
	frame_format_t format_latch;

	// a request is pending in every state but idle
	assign wr_valid = (state != W_IDLE);

	always_comb begin
		wr_req = '0;
		case (state)
			W_WIDTH: begin
				wr_req.address = `CTS_WIDTH_ADDR;
				wr_req.data = format_latch.width;
			end
			W_HEIGHT: begin
				wr_req.address = `CTS_HEIGHT_ADDR;
				wr_req.data = format_latch.height;
			end
			W_INTERLACE: begin
				wr_req.address = `CTS_INTERLACE_ADDR;
				wr_req.data = {12'd0, format_latch.interlaced};
			end
			default: begin
				wr_req = '0;
			end
		endcase
	end

	// width, height, interlace, each held until accepted
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= W_IDLE;
			write_done <= 1'b0;
		end else begin
			write_done <= 1'b0;
			case (state)
				W_IDLE: begin
					if (start_write) begin
						state <= W_WIDTH;
					end
				end
				W_WIDTH: begin
					if (wr_ready) begin
						state <= W_HEIGHT;
					end
				end
				W_HEIGHT: begin
					if (wr_ready) begin
						state <= W_INTERLACE;
					end
				end
				W_INTERLACE: begin
					if (wr_ready) begin
						state <= W_IDLE;
						write_done <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == W_IDLE && start_write) begin
			format_latch <= write_format;
		end
	end

endmodule

// ==== source/cts_sync_core.sv ====
`timescale 1ns/1ns
`include "cts_settings.svh"

module cts_sync_core import cts_pkg::*; (
	input logic clk,
	input logic rst,
	input stream_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,
	output stream_beat_t out_beat,
	output logic out_valid,
	input logic out_ready,
	output logic taken,
	output stream_beat_t taken_beat,
	input frame_format_t current_format,
	output logic start_write,
	output frame_format_t write_format,
	input logic write_done,
	input logic go_n,
	input logic disarm,
	output logic running_n
);

	stream_beat_t stage_beat;
	logic stage_valid;
	logic hold;
	sync_state_t state;
	logic [15:0] prev_width;
	logic [15:0] prev_height;
	logic width_changed;
	logic height_changed;
	logic trigger_always;
	logic trigger;
	logic video_header;

	// stream stage, frozen while held
	assign in_ready = out_ready & ~hold;
	assign out_valid = stage_valid & ~hold;
	assign out_beat = stage_beat;

	assign taken = in_valid & in_ready;
	assign taken_beat = in_beat;
	assign write_format = current_format;

	assign video_header = taken && in_beat.sop &&
		(packet_type_t'(in_beat.data[3:0]) == PKT_VIDEO);

	// interlace code alone never triggers
	assign width_changed = (`CTS_TRIGGER_ON_WIDTH != 0) && (prev_width != current_format.width);
	assign height_changed = (`CTS_TRIGGER_ON_HEIGHT != 0) &&
		(prev_height != current_format.height);
	assign trigger_always = (`CTS_TRIGGER_ON_WIDTH == 0) && (`CTS_TRIGGER_ON_HEIGHT == 0);
	assign trigger = width_changed | height_changed | trigger_always;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage_valid <= 1'b0;
		end else if (in_ready) begin
			stage_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_ready) begin
			stage_beat <= in_beat;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= WAIT_VIDEO_SOP;
			hold <= 1'b0;
			running_n <= 1'b1;
			start_write <= 1'b0;
			prev_width <= 16'd0;
			prev_height <= 16'd0;
		end else begin
			start_write <= 1'b0;
			case (state)
				WAIT_VIDEO_SOP: begin
					// header is now in the stage and stays there
					if (video_header) begin
						state <= STOPPED;
						hold <= 1'b1;
						running_n <= 1'b1;
					end
				end
				STOPPED: begin
					if (!go_n) begin
						if (trigger && !disarm) begin
							state <= WRITING;
							start_write <= 1'b1;
						end else begin
							state <= WAIT_VIDEO_SOP;
							hold <= 1'b0;
							running_n <= 1'b0;
							prev_width <= current_format.width;
							prev_height <= current_format.height;
						end
					end
				end
				WRITING: begin
					if (write_done) begin
						state <= WAIT_VIDEO_SOP;
						hold <= 1'b0;
						running_n <= 1'b0;
						prev_width <= current_format.width;
						prev_height <= current_format.height;
					end
				end
				default: begin
					state <= WAIT_VIDEO_SOP;
				end
			endcase
		end
	end

endmodule

// ==== source/cts_top.sv ====
`timescale 1ns/1ns
`include "cts_settings.svh"

module cts_top import cts_pkg::*; (
	input logic clk,
	input logic rst,
	input stream_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,
	output stream_beat_t out_beat,
	output logic out_valid,
	input logic out_ready,
	output reg_write_t wr_req,
	output logic wr_valid,
	input logic wr_ready,
	input logic go_n,
	input logic disarm,
	output logic running_n
);

	logic taken;
	stream_beat_t taken_beat;
	frame_format_t current_format;
	logic start_write;
	frame_format_t write_format;
	logic write_done;

	// watches accepted beats for control packets
	cts_format_decoder cts_format_decoder_inst (
		.clk(clk),
		.rst(rst),
		.taken(taken),
		.taken_beat(taken_beat),
		.current_format(current_format)
	);

	cts_register_writer cts_register_writer_inst (
		.clk(clk),
		.rst(rst),
		.start_write(start_write),
		.write_format(write_format),
		.write_done(write_done),
		.wr_req(wr_req),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready)
	);

	cts_sync_core cts_sync_core_inst (
		.clk(clk),
		.rst(rst),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.taken(taken),
		.taken_beat(taken_beat),
		.current_format(current_format),
		.start_write(start_write),
		.write_format(write_format),
		.write_done(write_done),
		.go_n(go_n),
		.disarm(disarm),
		.running_n(running_n)
	);

endmodule

// ==== bench/cts_clock_gen.sv ====
`timescale 1ns/1ns

module cts_clock_gen (
	output logic clk
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

endmodule

// ==== bench/cts_checker.sv ====
`timescale 1ns/1ns

module cts_checker import cts_pkg::*; (
	input logic clk,
	input logic rst,
	input stream_beat_t out_beat,
	input logic out_valid,
	input logic out_ready,
	input logic in_ready,
	input sync_state_t state,
	input logic start_write
);

	// a stalled output beat stays valid and unchanged
	assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
		else $error("output beat changed or vanished under back-pressure");

	// stopped or writing keeps both sides of the stage closed
	assert property (@(posedge clk) disable iff (rst)
		state != WAIT_VIDEO_SOP |-> !out_valid && !in_ready)
		else $error("stream moved while the core was stopped or writing");

	// the parked beat is the video header that caused the stop
	assert property (@(posedge clk) disable iff (rst)
		state != WAIT_VIDEO_SOP |-> out_beat.sop &&
		(packet_type_t'(out_beat.data[3:0]) == PKT_VIDEO))
		else $error("beat parked in the stage is not a video header");

	assert property (@(posedge clk) disable iff (rst) start_write |=> !start_write)
		else $error("start_write longer than one cycle");

endmodule

// ==== bench/cts_tb.sv ====
`timescale 1ns/1ns
`include "cts_settings.svh"

module cts_tb import cts_pkg::*; ();

	typedef struct packed {
		logic is_control;
		logic [15:0] width;
		logic [15:0] height;
		logic [3:0] interlaced;
		logic [7:0] beats;
		logic [7:0] go_delay;
		logic disarm;
		logic [1:0] writes;
	} test_entry_t;

	localparam int NUM_TESTS = 13;
	// control rows carry a format, video rows a frame length and release timing
	localparam test_entry_t TESTS [NUM_TESTS] = '{
		'{1'b1, 16'd1920, 16'd1080, 4'd0, 8'd4, 8'd0, 1'b0, 2'd0},
		'{1'b0, 16'd0, 16'd0, 4'd0, 8'd6, 8'd3, 1'b0, 2'd3},
		'{1'b1, 16'd1920, 16'd1080, 4'd1, 8'd4, 8'd0, 1'b0, 2'd0},
		'{1'b0, 16'd0, 16'd0, 4'd0, 8'd4, 8'd2, 1'b0, 2'd0},
		'{1'b1, 16'd1280, 16'd720, 4'd0, 8'd4, 8'd0, 1'b0, 2'd0},
		'{1'b0, 16'd0, 16'd0, 4'd0, 8'd5, 8'd1, 1'b1, 2'd0},
		'{1'b0, 16'd0, 16'd0, 4'd0, 8'd3, 8'd2, 1'b0, 2'd0},
		'{1'b1, 16'd1280, 16'd1024, 4'd2, 8'd4, 8'd0, 1'b0, 2'd0},
		'{1'b0, 16'd0, 16'd0, 4'd0, 8'd5, 8'd6, 1'b0, 2'd3},
		'{1'b1, 16'd1280, 16'd1024, 4'd2, 8'd4, 8'd0, 1'b0, 2'd0},
		'{1'b0, 16'd0, 16'd0, 4'd0, 8'd2, 8'd1, 1'b0, 2'd0},
		'{1'b1, 16'd640, 16'd1024, 4'd0, 8'd4, 8'd0, 1'b0, 2'd0},
		'{1'b0, 16'd0, 16'd0, 4'd0, 8'd4, 8'd4, 1'b0, 2'd3}
	};

	logic clk;
	logic rst;
	stream_beat_t in_beat;
	logic in_valid;
	logic in_ready;
	stream_beat_t out_beat;
	logic out_valid;
	logic out_ready;
	reg_write_t wr_req;
	logic wr_valid;
	logic wr_ready;
	logic go_n;
	logic disarm;
	logic running_n;

	logic [31:0] rng_state = 32'd64275;
	stream_beat_t send_q[$];
	stream_beat_t expect_q[$];
	reg_write_t write_q[$];
	frame_format_t model_cur;
	frame_format_t model_prev;
	logic model_running;
	logic header_taken;
	logic go_hold;
	logic disarm_level;
	int held_cycles;

	cts_clock_gen cts_clock_gen_inst (
		.clk(clk)
	);

	cts_top cts_top_inst (
		.clk(clk),
		.rst(rst),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.wr_req(wr_req),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.go_n(go_n),
		.disarm(disarm),
		.running_n(running_n)
	);

	bind cts_sync_core cts_checker cts_checker_inst (
		.clk(clk),
		.rst(rst),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.in_ready(in_ready),
		.state(state),
		.start_write(start_write)
	);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic stream_beat_t make_beat(logic [`CTS_DATA_WIDTH-1:0] data, logic sop,
		logic eop);
		stream_beat_t b;
		b.data = data;
		b.sop = sop;
		b.eop = eop;
		return b;
	endfunction

	// low nibble per symbol, symbol 0 first; upper nibbles are noise
	function automatic logic [`CTS_DATA_WIDTH-1:0] pack_nibbles(logic [3:0] n0, logic [3:0] n1,
		logic [3:0] n2);
		logic [31:0] r;
		r = next_random();
		return {r[11:8], n2, r[7:4], n1, r[3:0], n0};
	endfunction

	function automatic reg_write_t make_write(logic [7:0] address, logic [15:0] data);
		reg_write_t w;
		w.address = address;
		w.data = data;
		return w;
	endfunction

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_failure(string what);
		$display("%s", what);
		abort_run();
	endtask

	task automatic compare_beat(string name, stream_beat_t got, stream_beat_t want);
		if (got !== want) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic compare_write(string name, reg_write_t got, reg_write_t want);
		if (got !== want) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic compare_bit(string name, logic got, logic want);
		if (got !== want) begin
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	// queue one packet and predict its register writes
	task automatic load_packet(test_entry_t t);
		logic [31:0] r;
		int predicted;
		r = next_random();
		if (t.is_control) begin
			send_q.push_back(make_beat({r[23:4], 4'hf}, 1'b1, 1'b0));
			send_q.push_back(make_beat(pack_nibbles(t.width[15:12], t.width[11:8],
				t.width[7:4]), 1'b0, 1'b0));
			send_q.push_back(make_beat(pack_nibbles(t.width[3:0], t.height[15:12],
				t.height[11:8]), 1'b0, 1'b0));
			send_q.push_back(make_beat(pack_nibbles(t.height[7:4], t.height[3:0],
				t.interlaced), 1'b0, 1'b1));
			model_cur.width = t.width;
			model_cur.height = t.height;
			model_cur.interlaced = t.interlaced;
		end else begin
			send_q.push_back(make_beat({r[23:4], 4'h0}, 1'b1, 1'b0));
			for (int b = 1; b < int'(t.beats); b++) begin
				r = next_random();
				send_q.push_back(make_beat(r[23:0], 1'b0, b == int'(t.beats) - 1));
			end
			// interlace code alone is no change
			predicted = ((model_cur.width != model_prev.width ||
				model_cur.height != model_prev.height) && !t.disarm) ? 3 : 0;
			if (predicted != int'(t.writes)) begin
				report_failure("table write count disagrees with the format history");
			end
			if (predicted == 3) begin
				write_q.push_back(make_write(`CTS_WIDTH_ADDR, model_cur.width));
				write_q.push_back(make_write(`CTS_HEIGHT_ADDR, model_cur.height));
				write_q.push_back(make_write(`CTS_INTERLACE_ADDR, {12'd0, model_cur.interlaced}));
			end
			model_prev = model_cur;
			model_running = 1'b0;
		end
	endtask

	// drive on the falling edge, judge the coming rising edge 1 ns later
	task automatic step();
		logic [31:0] r;
		stream_beat_t want_beat;
		reg_write_t want_write;
		r = next_random();
		@(negedge clk);
		out_ready = (r[1:0] != 2'b00);
		wr_ready = (r[5:4] != 2'b00);
		go_n = go_hold;
		disarm = disarm_level;
		in_valid = (send_q.size() != 0);
		in_beat = (send_q.size() != 0) ? send_q[0] : '0;
		#1;
		// a stopped frame accepts nothing more
		if (header_taken && (go_hold || write_q.size() != 0)) begin
			compare_bit("in_ready", in_ready, 1'b0);
		end
		if (out_valid && out_ready) begin
			if (expect_q.size() == 0) begin
				report_failure("output beat appeared with no beat outstanding");
			end
			if (header_taken && (go_hold || write_q.size() != 0)) begin
				report_failure("beat of a held frame left before its release");
			end
			want_beat = expect_q.pop_front();
			compare_beat("out_beat", out_beat, want_beat);
		end
		if (wr_valid && go_hold) begin
			report_failure("register write requested before go_n was released");
		end
		if (wr_valid && wr_ready) begin
			if (write_q.size() == 0) begin
				report_failure("register write appeared where none was due");
			end
			want_write = write_q.pop_front();
			compare_write("wr_req", wr_req, want_write);
		end
		if (in_valid && in_ready) begin
			if (in_beat.sop && in_beat.data[3:0] == 4'h0) begin
				header_taken = 1'b1;
			end
			expect_q.push_back(send_q.pop_front());
		end
	endtask

	initial begin : watchdog
		int limit;
		limit = 500;
		for (int i = 0; i < NUM_TESTS; i++) begin
			limit = limit + int'(TESTS[i].beats) * 20;
		end
		repeat (limit) @(posedge clk);
		report_failure($sformatf("timeout, run still busy after %0d cycles", limit));
	end

	initial begin
		rst = 1'b1;
		in_beat = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		wr_ready = 1'b0;
		go_n = 1'b1;
		disarm = 1'b0;
		go_hold = 1'b1;
		disarm_level = 1'b0;
		header_taken = 1'b0;
		held_cycles = 0;
		model_cur = '0;
		model_prev = '0;
		model_running = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		compare_bit("running_n", running_n, 1'b1);
		compare_bit("out_valid", out_valid, 1'b0);
		compare_bit("wr_valid", wr_valid, 1'b0);
		for (int i = 0; i < NUM_TESTS; i++) begin
			load_packet(TESTS[i]);
			header_taken = 1'b0;
			held_cycles = 0;
			go_hold = 1'b1;
			disarm_level = TESTS[i].disarm;
			while (send_q.size() != 0 || expect_q.size() != 0 || write_q.size() != 0) begin
				step();
				// frame parked at its header until go_n drops
				if (header_taken && go_hold) begin
					if (held_cycles > 0) begin
						compare_bit("running_n", running_n, 1'b1);
					end
					held_cycles++;
					if (held_cycles > int'(TESTS[i].go_delay)) begin
						go_hold = 1'b0;
					end
				end
			end
			compare_bit("running_n", running_n, model_running);
		end
		// idle tail, nothing more may come out
		repeat (20) step();
		if (send_q.size() != 0 || expect_q.size() != 0 || write_q.size() != 0) begin
			report_failure("beats or writes still outstanding at the end of the run");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
+incdir+common
common/cts_pkg.sv
source/cts_format_decoder.sv
source/cts_register_writer.sv
source/cts_sync_core.sv
source/cts_top.sv
bench/cts_clock_gen.sv
bench/cts_checker.sv
bench/cts_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --assert -j 0
TOP = cts_tb
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
